/* common/cvu_pkg.sv */
package cvu_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    // One real or imaginary half
    localparam int DATA_WIDTH = 16;

    // One memory word holds a full complex sample
    localparam int WORD_WIDTH = 2 * DATA_WIDTH;

    // 256 words of sample memory
    localparam int DM_ADDR_WIDTH = 8;

    // Host instruction word
    localparam int INST_WIDTH = 32;

    // Length field holds element count minus one
    localparam int LEN_WIDTH = 5;

    // Opcode field width
    localparam int OP_WIDTH = 2;

    //////////////////////////////
    // Instruction fields
    //////////////////////////////

    // Low bit of each field
    // Bit 31 stays reserved
    localparam int RADDR0_LSB = 0;
    localparam int RADDR1_LSB = 8;
    localparam int WADDR_LSB  = 16;
    localparam int LEN_LSB    = 24;
    localparam int OP_LSB     = 29;

    // Operations
    typedef enum logic [OP_WIDTH-1:0] {
        OP_LOAD = 2'd0,
        OP_CADD = 2'd1,
        OP_CMUL = 2'd2,
        OP_WADD = 2'd3
    } cvu_op_e;

    //////////////////////////////
    // Sample word
    //////////////////////////////

    // Complex view with real part in the upper half
    typedef struct packed {
        logic signed [DATA_WIDTH-1:0] re;
        logic signed [DATA_WIDTH-1:0] im;
    } cvu_cplx_t;

    // Same word seen as complex pair or as plain integer
    typedef union packed {
        cvu_cplx_t               cplx;
        logic [WORD_WIDTH-1:0]   raw;
    } cvu_word_t;

endpackage

/* data_mem/data_mem.sv */
`timescale 1ns/10ps

module data_mem (
    input  logic                           clk,
    input  logic                           rst,
    // Instruction carries the three base addresses
    input  logic                           inst_v,
    input  logic [cvu_pkg::INST_WIDTH-1:0] inst,
    // Access strobes from the sequencer
    input  logic                           rden,
    input  logic                           wren,
    input  cvu_pkg::cvu_word_t             wdata,
    // Operand pair, one cycle after the registered read strobe
    output logic                           rvalid,
    output cvu_pkg::cvu_word_t             rdata0,
    output cvu_pkg::cvu_word_t             rdata1
);

    localparam int DEPTH = 2 ** cvu_pkg::DM_ADDR_WIDTH;

    // Sample storage
    cvu_pkg::cvu_word_t mem [0:DEPTH-1];

    // Auto-stepping address registers
    logic [cvu_pkg::DM_ADDR_WIDTH-1:0] raddr0;
    logic [cvu_pkg::DM_ADDR_WIDTH-1:0] raddr1;
    logic [cvu_pkg::DM_ADDR_WIDTH-1:0] waddr;

    // Strobes and write data delayed by one cycle
    logic               rden_r;
    logic               wren_r;
    cvu_pkg::cvu_word_t wdata_r;

    //////////////////////////////
    // Strobe registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rden_r <= 1'b0;
            wren_r <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            rden_r <= rden;
            wren_r <= wren;
            // Read data lands one cycle after rden_r
            rvalid <= rden_r;
        end
    end

    // Write word travels with wren_r
    always_ff @(posedge clk) begin
        wdata_r <= wdata;
    end

    //////////////////////////////
    // Address registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            raddr0 <= '0;
            raddr1 <= '0;
            waddr  <= '0;
        end else if (inst_v) begin
            raddr0 <= inst[cvu_pkg::RADDR0_LSB +: cvu_pkg::DM_ADDR_WIDTH];
            raddr1 <= inst[cvu_pkg::RADDR1_LSB +: cvu_pkg::DM_ADDR_WIDTH];
            waddr  <= inst[cvu_pkg::WADDR_LSB +: cvu_pkg::DM_ADDR_WIDTH];
        end else begin
            // Both operands step together
            if (rden_r) begin
                raddr0 <= raddr0 + 1'b1;
                raddr1 <= raddr1 + 1'b1;
            end
            if (wren_r) begin
                waddr <= waddr + 1'b1;
            end
        end
    end

    // Array port, read returns old contents on a collision
    always_ff @(posedge clk) begin
        if (wren_r) begin
            mem[waddr] <= wdata_r;
        end
        if (rden_r) begin
            rdata0 <= mem[raddr0];
            rdata1 <= mem[raddr1];
        end
    end

    // New base addresses never arrive while a write is still pending
    a_inst_no_write: assert property (@(posedge clk) disable iff (rst)
        inst_v |-> !wren_r)
        else $error("data_mem: instruction load collides with a pending write");

endmodule

/* hdl/vec_sequencer.sv */
`timescale 1ns/10ps

module vec_sequencer (
    input  logic                           clk,
    input  logic                           rst,
    // Host instruction
    input  logic                           inst_v,
    input  logic [cvu_pkg::INST_WIDTH-1:0] inst,
    // Host load stream
    input  logic                           load_v,
    input  cvu_pkg::cvu_word_t             load_data,
    // Arithmetic results
    input  logic                           result_v,
    input  cvu_pkg::cvu_word_t             result,
    // Memory side
    output logic                           mem_inst_v,
    output logic [cvu_pkg::INST_WIDTH-1:0] mem_inst,
    output logic                           rden,
    output logic                           wren,
    output cvu_pkg::cvu_word_t             wdata,
    // Op level for the arithmetic unit
    output cvu_pkg::cvu_op_e               op,
    // Host status
    output logic                           busy,
    output logic                           done
);

    // Fields of the incoming word
    cvu_pkg::cvu_op_e                inst_op;
    logic [cvu_pkg::LEN_WIDTH-1:0]   inst_len;

    // Accepted instruction
    logic                            start;
    logic                            is_load;
    logic [cvu_pkg::LEN_WIDTH-1:0]   len_q;

    // Element counters
    logic [cvu_pkg::LEN_WIDTH-1:0]   rd_cnt;
    logic [cvu_pkg::LEN_WIDTH-1:0]   wr_cnt;

    // High while writes are still expected
    logic                            wr_open;
    // Commit cycle of the final write
    logic                            last_wr;

    //////////////////////////////
    // Decode
    //////////////////////////////

    assign inst_op  = cvu_pkg::cvu_op_e'(inst[cvu_pkg::OP_LSB +: cvu_pkg::OP_WIDTH]);
    assign inst_len = inst[cvu_pkg::LEN_LSB +: cvu_pkg::LEN_WIDTH];

    // Only an idle unit takes a new instruction
    assign start   = inst_v && !busy;
    assign is_load = (op == cvu_pkg::OP_LOAD);

    // Forwarded copy, valid with mem_inst_v
    always_ff @(posedge clk) begin
        if (start) begin
            mem_inst <= inst;
        end
    end

    //////////////////////////////
    // Control
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            mem_inst_v <= 1'b0;
            op         <= cvu_pkg::OP_LOAD;
            len_q      <= '0;
        end else begin
            mem_inst_v <= start;
            // Done follows the commit cycle
            done       <= last_wr;
            if (start) begin
                busy  <= 1'b1;
                op    <= inst_op;
                len_q <= inst_len;
            end else if (last_wr) begin
                busy  <= 1'b0;
            end
        end
    end

    // Read strobes, one per element, compute ops only
    always_ff @(posedge clk) begin
        if (rst) begin
            rden   <= 1'b0;
            rd_cnt <= '0;
        end else if (start) begin
            rden   <= (inst_op != cvu_pkg::OP_LOAD);
            rd_cnt <= '0;
        end else if (rden) begin
            if (rd_cnt == len_q) begin
                rden <= 1'b0;
            end else begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    // Write counting
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_open <= 1'b0;
            wr_cnt  <= '0;
            last_wr <= 1'b0;
        end else begin
            last_wr <= 1'b0;
            if (start) begin
                wr_open <= 1'b1;
                wr_cnt  <= '0;
            end else if (wren) begin
                if (wr_cnt == len_q) begin
                    // Memory commits this one next cycle
                    wr_open <= 1'b0;
                    last_wr <= 1'b1;
                end else begin
                    wr_cnt <= wr_cnt + 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // Write source
    //////////////////////////////

    // Host words during LOAD, results otherwise
    assign wren  = wr_open && (is_load ? load_v : result_v);
    assign wdata = is_load ? load_data : result;

    // Host waits for busy to fall
    a_no_inst_busy: assert property (@(posedge clk) disable iff (rst)
        inst_v |-> !busy)
        else $error("vec_sequencer: instruction while busy");

    // Results only belong to a running compute op
    a_result_in_compute: assert property (@(posedge clk) disable iff (rst)
        result_v |-> (busy && !is_load))
        else $error("vec_sequencer: result outside a compute instruction");

endmodule

/* hdl/cplx_alu.sv */
`timescale 1ns/10ps

module cplx_alu (
    input  logic               clk,
    input  logic               rst,
    // Held stable by the sequencer while busy
    input  cvu_pkg::cvu_op_e   op,
    // Operand pair from memory
    input  logic               rvalid,
    input  cvu_pkg::cvu_word_t rdata0,
    input  cvu_pkg::cvu_word_t rdata1,
    // Two cycles after rvalid
    output logic               result_v,
    output cvu_pkg::cvu_word_t result
);

    // Product and difference widths
    localparam int PROD_W  = 2 * cvu_pkg::DATA_WIDTH;
    localparam int ACC_W   = PROD_W + 1;
    // Q1.15 scaling
    localparam int Q_SHIFT = cvu_pkg::DATA_WIDTH - 1;

    // Halfwise or raw sum of the current pair
    cvu_pkg::cvu_word_t        sum_c;

    // Stage 1
    logic                      s1_v;
    logic signed [PROD_W-1:0]  s1_ac;
    logic signed [PROD_W-1:0]  s1_bd;
    logic signed [PROD_W-1:0]  s1_ad;
    logic signed [PROD_W-1:0]  s1_bc;
    cvu_pkg::cvu_word_t        s1_sum;

    // Stage 2 combine
    logic signed [ACC_W-1:0]   re_full;
    logic signed [ACC_W-1:0]   im_full;
    logic signed [ACC_W-1:0]   re_shift;
    logic signed [ACC_W-1:0]   im_shift;
    cvu_pkg::cvu_word_t        prod_w;

    //////////////////////////////
    // Stage 1
    //////////////////////////////

    // WADD sees plain integers, CADD sees two halves
    always_comb begin
        sum_c = '0;
        if (op == cvu_pkg::OP_WADD) begin
            // Carry crosses the half boundary
            sum_c.raw = rdata0.raw + rdata1.raw;
        end else begin
            // Each half wraps on its own
            sum_c.cplx.re = rdata0.cplx.re + rdata1.cplx.re;
            sum_c.cplx.im = rdata0.cplx.im + rdata1.cplx.im;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_v <= 1'b0;
        end else begin
            s1_v <= rvalid;
        end
    end

    // (a + jb) * (c + jd) cross products
    always_ff @(posedge clk) begin
        if (rvalid) begin
            s1_ac  <= rdata0.cplx.re * rdata1.cplx.re;
            s1_bd  <= rdata0.cplx.im * rdata1.cplx.im;
            s1_ad  <= rdata0.cplx.re * rdata1.cplx.im;
            s1_bc  <= rdata0.cplx.im * rdata1.cplx.re;
            s1_sum <= sum_c;
        end
    end

    //////////////////////////////
    // Stage 2
    //////////////////////////////

    // One extra bit keeps the difference exact
    always_comb begin
        re_full  = s1_ac - s1_bd;
        im_full  = s1_ad + s1_bc;
        re_shift = re_full >>> Q_SHIFT;
        im_shift = im_full >>> Q_SHIFT;
        // Truncate back to Q1.15, no saturation
        prod_w.cplx.re = re_shift[cvu_pkg::DATA_WIDTH-1:0];
        prod_w.cplx.im = im_shift[cvu_pkg::DATA_WIDTH-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_v <= 1'b0;
        end else begin
            result_v <= s1_v;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_v) begin
            result <= (op == cvu_pkg::OP_CMUL) ? prod_w : s1_sum;
        end
    end

    // Both stages must see the same op for one element
    a_op_stable: assert property (@(posedge clk) disable iff (rst)
        s1_v |-> $stable(op))
        else $error("cplx_alu: op changed with an element in flight");

endmodule

/* hdl/cvu_top.sv */
`timescale 1ns/10ps

module cvu_top (
    input  logic                           clk,
    input  logic                           rst,
    // Host instruction
    input  logic                           inst_v,
    input  logic [cvu_pkg::INST_WIDTH-1:0] inst,
    // Host load stream
    input  logic                           load_v,
    input  cvu_pkg::cvu_word_t             load_data,
    // Status
    output logic                           busy,
    output logic                           done,
    // Every result word, also written back
    output logic                           result_v,
    output cvu_pkg::cvu_word_t             result
);

    //////////////////////////////
    // Internal nets
    //////////////////////////////

    // Sequencer to memory
    logic                           mem_inst_v;
    logic [cvu_pkg::INST_WIDTH-1:0] mem_inst;
    logic                           rden;
    logic                           wren;
    cvu_pkg::cvu_word_t             wdata;

    // Memory to arithmetic unit
    logic                           rvalid;
    cvu_pkg::cvu_word_t             rdata0;
    cvu_pkg::cvu_word_t             rdata1;

    // Op level
    cvu_pkg::cvu_op_e               op;

    // Decode, strobes, write source
    vec_sequencer vec_sequencer_i (
        .clk        (clk),
        .rst        (rst),
        .inst_v     (inst_v),
        .inst       (inst),
        .load_v     (load_v),
        .load_data  (load_data),
        .result_v   (result_v),
        .result     (result),
        .mem_inst_v (mem_inst_v),
        .mem_inst   (mem_inst),
        .rden       (rden),
        .wren       (wren),
        .wdata      (wdata),
        .op         (op),
        .busy       (busy),
        .done       (done)
    );

    // Sample storage
    data_mem data_mem_i (
        .clk    (clk),
        .rst    (rst),
        .inst_v (mem_inst_v),
        .inst   (mem_inst),
        .rden   (rden),
        .wren   (wren),
        .wdata  (wdata),
        .rvalid (rvalid),
        .rdata0 (rdata0),
        .rdata1 (rdata1)
    );

    // Two-stage arithmetic
    cplx_alu cplx_alu_i (
        .clk      (clk),
        .rst      (rst),
        .op       (op),
        .rvalid   (rvalid),
        .rdata0   (rdata0),
        .rdata1   (rdata1),
        .result_v (result_v),
        .result   (result)
    );

endmodule

/* bench/cvu_tb.sv */
`timescale 1ns/10ps

module cvu_tb;

    //////////////////////////////
    // DUT signals
    //////////////////////////////

    logic                           clk = 1'b0;
    logic                           rst;
    logic                           inst_v;
    logic [cvu_pkg::INST_WIDTH-1:0] inst;
    logic                           load_v;
    cvu_pkg::cvu_word_t             load_data;
    logic                           busy;
    logic                           done;
    logic                           result_v;
    cvu_pkg::cvu_word_t             result;

    // Records from the data file
    logic [cvu_pkg::INST_WIDTH-1:0] inst_q[$];
    int                             base_q[$];
    int                             len_q[$];
    // Load words and expected results, in file order
    cvu_pkg::cvu_word_t             word_q[$];

    // Run bookkeeping
    int cycle_cnt      = 0;
    int cycle_limit    = 0;
    int result_total   = 0;
    int expected_total = 0;
    int rec;

    cvu_top cvu_top_i (
        .clk       (clk),
        .rst       (rst),
        .inst_v    (inst_v),
        .inst      (inst),
        .load_v    (load_v),
        .load_data (load_data),
        .busy      (busy),
        .done      (done),
        .result_v  (result_v),
        .result    (result)
    );

    // 20 ns period
    always #10 clk = ~clk;

    //////////////////////////////
    // Monitors
    //////////////////////////////

    // Budget from the record lengths
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: done never arrived");
            $display("Simulation FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    // Every result pulse over the run, sampled mid-cycle
    always @(negedge clk) begin
        if (rst === 1'b0 && result_v === 1'b1) begin
            result_total = result_total + 1;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic check_result(cvu_pkg::cvu_word_t got, cvu_pkg::cvu_word_t exp,
                                string what);
        // Both views of the word must agree
        if (got.cplx.re !== exp.cplx.re || got.cplx.im !== exp.cplx.im
                || got.raw !== exp.raw) begin
            $display("[ERROR] t=%0t %s: got %h (re %0d im %0d), expected %h (re %0d im %0d)",
                     $time, what, got.raw, got.cplx.re, got.cplx.im,
                     exp.raw, exp.cplx.re, exp.cplx.im);
            $display("Simulation FAILED");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_count(int got, int exp, string what);
        if (got != exp) begin
            $display("[ERROR] t=%0t %s: got %0d, expected %0d", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic check_level(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s: got %b, expected %b", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "status mismatch");
        end
    endtask

    task automatic data_error(string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "bad test data");
    endtask

    //////////////////////////////
    // Data file
    //////////////////////////////

    task automatic read_records();
        int               fd;
        int               code;
        int               n;
        int               k;
        logic [31:0]      val;
        logic [8*8-1:0]   kind;
        logic [8*128-1:0] rest;
        bit               at_end;
        cvu_pkg::cvu_op_e op_f;
        fd = $fopen("bench/cvu_testdata.txt", "r");
        if (fd == 0) begin
            data_error("could not open bench/cvu_testdata.txt");
        end else begin
            at_end = 1'b0;
            while (!at_end) begin
                kind = '0;
                code = $fscanf(fd, "%s", kind);
                if (code != 1) begin
                    data_error("test data ended without an end record");
                end else if (kind == "#") begin
                    // Rest of a comment line
                    code = $fgets(rest, fd);
                end else if (kind == "E") begin
                    at_end = 1'b1;
                end else if (kind == "L" || kind == "C") begin
                    code = $fscanf(fd, "%h", val);
                    op_f = cvu_pkg::cvu_op_e'(val[cvu_pkg::OP_LSB +: cvu_pkg::OP_WIDTH]);
                    n    = val[cvu_pkg::LEN_LSB +: cvu_pkg::LEN_WIDTH] + 1;
                    if (code != 1 || ((kind == "L") != (op_f == cvu_pkg::OP_LOAD))) begin
                        data_error("record kind does not match its instruction");
                    end else begin
                        inst_q.push_back(val);
                        base_q.push_back(word_q.size());
                        len_q.push_back(n);
                        // Issue, drain and idle slack per record
                        cycle_limit = cycle_limit + n + 12;
                        if (kind == "C") begin
                            expected_total = expected_total + n;
                        end
                        for (k = 0; k < n; k++) begin
                            code = $fscanf(fd, "%h", val);
                            if (code != 1) begin
                                data_error("test data ended inside a record");
                            end else begin
                                word_q.push_back(val);
                            end
                        end
                    end
                end else begin
                    data_error("unknown record kind in test data");
                end
            end
            $fclose(fd);
            cycle_limit = cycle_limit + 20;
        end
    endtask

    //////////////////////////////
    // Host sequences
    //////////////////////////////

    // Drive point, 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic load_vector(logic [cvu_pkg::INST_WIDTH-1:0] word, int base, int n);
        int k;
        inst_v = 1'b1;
        inst   = word;
        next_cycle();
        inst_v = 1'b0;
        check_level(busy, 1'b1, "busy after LOAD issue");
        check_level(done, 1'b0, "done after LOAD issue");
        for (k = 0; k < n; k++) begin
            load_v    = 1'b1;
            load_data = word_q[base + k];
            next_cycle();
        end
        load_v    = 1'b0;
        load_data = '0;
        while (done !== 1'b1) begin
            next_cycle();
        end
        check_level(busy, 1'b0, "busy in the LOAD done cycle");
        // Idle strobes land on the next free address if not ignored
        for (k = 0; k < 2; k++) begin
            load_v        = 1'b1;
            load_data.raw = 32'hdead_0000 + k;
            next_cycle();
        end
        load_v    = 1'b0;
        load_data = '0;
    endtask

    task automatic compute_vector(logic [cvu_pkg::INST_WIDTH-1:0] word, int base, int n);
        int got;
        inst_v = 1'b1;
        inst   = word;
        next_cycle();
        inst_v = 1'b0;
        got    = 0;
        check_level(busy, 1'b1, "busy after compute issue");
        check_level(done, 1'b0, "done after compute issue");
        while (done !== 1'b1) begin
            if (result_v === 1'b1) begin
                if (got >= n) begin
                    check_count(got + 1, n, "result pulses for one instruction");
                end else begin
                    check_result(result, word_q[base + got],
                                 $sformatf("element %0d of instruction %h", got, word));
                end
                got = got + 1;
            end
            next_cycle();
        end
        // Results all arrive before done
        check_count(got, n, "result pulses before done");
        check_level(busy, 1'b0, "busy in the compute done cycle");
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        rst       = 1'b1;
        inst_v    = 1'b0;
        inst      = '0;
        load_v    = 1'b0;
        load_data = '0;
        read_records();

        // Status stays quiet through reset
        repeat (3) begin
            next_cycle();
            check_level(busy, 1'b0, "busy in reset");
            check_level(done, 1'b0, "done in reset");
            check_level(result_v, 1'b0, "result_v in reset");
        end
        rst = 1'b0;
        next_cycle();
        check_level(busy, 1'b0, "busy in first idle cycle");
        check_level(done, 1'b0, "done in first idle cycle");
        check_level(result_v, 1'b0, "result_v in first idle cycle");

        // Each record issued as soon as busy is low
        for (rec = 0; rec < inst_q.size(); rec++) begin
            if (inst_q[rec][cvu_pkg::OP_LSB +: cvu_pkg::OP_WIDTH] == cvu_pkg::OP_LOAD) begin
                load_vector(inst_q[rec], base_q[rec], len_q[rec]);
            end else begin
                compute_vector(inst_q[rec], base_q[rec], len_q[rec]);
            end
        end

        repeat (2) begin
            next_cycle();
        end
        check_count(result_total, expected_total, "result pulses over the whole run");
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* bench/cvu_testdata.txt */
# Record: kind (L load, C compute, E end), instruction in hex, then N words in hex
# L words go to memory in order, C words are the expected results in order
# Vector y at 0x10
L 03100000
00030004 0001ffff 00000001 ffffffff
# Vector x at 0x0c, ends right below y
L 030c0000
00010002 7fff8000 1234ffff ffffffff
# CADD x + y to 0x20, each half wraps
C 2320100c
00040006 80007fff 12340000 fffefffe
# WADD on the same words to 0x24, carry crosses the halves
C 6324100c
00040006 80017fff 12350000 fffffffe
# CMUL operands, p at 0x30 and q at 0x35
L 09300000
40000000 80000000 00004000 c0002000 00010000
40000000 80000000 00004000 2000c000 ffff0000
# CMUL p * q to 0x28, Q1.15 truncated, -1 * -1 wraps
C 44283530
20000000 80000000 e0000000 00002800 ffff0000
# CADD of the CADD and WADD results to 0x40
C 23402420
0008000c 0001fffe 24690000 fffdfffc
# Ramp of 32 words at 0x80
L 1f800000
0001ffff 0002fffe 0003fffd 0004fffc
0005fffb 0006fffa 0007fff9 0008fff8
0009fff7 000afff6 000bfff5 000cfff4
000dfff3 000efff2 000ffff1 0010fff0
0011ffef 0012ffee 0013ffed 0014ffec
0015ffeb 0016ffea 0017ffe9 0018ffe8
0019ffe7 001affe6 001bffe5 001cffe4
001dffe3 001effe2 001fffe1 0020ffe0
# Ramp added to itself, written to 0xa0
C 3fa08080
0002fffe 0004fffc 0006fffa 0008fff8
000afff6 000cfff4 000efff2 0010fff0
0012ffee 0014ffec 0016ffea 0018ffe8
001affe6 001cffe4 001effe2 0020ffe0
0022ffde 0024ffdc 0026ffda 0028ffd8
002affd6 002cffd4 002effd2 0030ffd0
0032ffce 0034ffcc 0036ffca 0038ffc8
003affc6 003cffc4 003effc2 0040ffc0
# WADD of last and first doubled words, one element to 0xff
C 60ffa0bf
0043ffbe
E

/* sim.f */
common/cvu_pkg.sv
data_mem/data_mem.sv
hdl/vec_sequencer.sv
hdl/cplx_alu.sv
hdl/cvu_top.sv
bench/cvu_tb.sv
